//--- apb/udma_apb_if.sv
/*
 * APB slave for the uDMA core.
 * Splits PADDR into target index and register address and forwards
 * each access on the shared peripheral register bus.
 */

`timescale 1ns/1ps
`default_nettype none

module udma_apb_if #(
    parameter int N_PERIPHS = 4
) (
    input  logic [udma_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
    input  logic [udma_pkg::APB_DATA_WIDTH-1:0]  pwdata_i,
    input  logic                                 pwrite_i,
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    output logic [udma_pkg::APB_DATA_WIDTH-1:0]  prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,

    output logic [udma_pkg::APB_DATA_WIDTH-1:0]  per_data_o,
    output logic [udma_pkg::REG_ADDR_WIDTH-1:0]  per_addr_o,
    output logic                                 per_rwn_o,
    output logic [N_PERIPHS:0]                   per_valid_o,
    input  logic [N_PERIPHS:0][udma_pkg::APB_DATA_WIDTH-1:0] per_rdata_i,
    input  logic [N_PERIPHS:0]                   per_ready_i
);

    import udma_pkg::*;

    logic [PER_ID_WIDTH-1:0] per_id;
    logic                    access;
    logic                    out_of_range;

    assign per_id       = paddr_i[11:7];
    assign access       = psel_i & penable_i;
    assign out_of_range = (per_id > N_PERIPHS);

    // The bus fields are shared, only the valid lines are per target
    assign per_data_o = pwdata_i;
    assign per_addr_o = paddr_i[6:2];
    assign per_rwn_o  = ~pwrite_i;

    always_comb
    begin
        for (int i = 0; i <= N_PERIPHS; i++)
        begin
            per_valid_o[i] = access && (per_id == PER_ID_WIDTH'(i));
        end
    end

    ////////////////////////////////////////
    // Response mux
    ////////////////////////////////////////

    always_comb
    begin
        prdata_o  = '0;
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        for (int i = 0; i <= N_PERIPHS; i++)
        begin
            if (per_id == PER_ID_WIDTH'(i))
            begin
                prdata_o = per_rdata_i[i];
                pready_o = per_ready_i[i];
            end
        end
        // Nobody sits at this index, so answer at once with an error
        if (out_of_range)
        begin
            prdata_o  = '0;
            pready_o  = 1'b1;
            pslverr_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- common/udma_pkg.sv
/*
 * Shared definitions for the uDMA configuration core.
 * Holds bus widths, address field layout, the control register map
 * and the control word union.
 */

`default_nettype none

package udma_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    // PADDR[11:7] selects the target, PADDR[6:2] the register
    localparam int PER_ID_WIDTH   = 5;
    localparam int REG_ADDR_WIDTH = 5;

    localparam int EVT_ID_WIDTH = 8;
    localparam int N_EVT_OUT    = 4;

    ////////////////////////////////////////
    // Control unit register map
    ////////////////////////////////////////

    localparam logic [REG_ADDR_WIDTH-1:0] CTRL_REG_CG  = 5'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] CTRL_REG_EVT = 5'd1;

    // One control word seen either as a raw mask word or as select bytes
    typedef union packed {
        logic [APB_DATA_WIDTH-1:0]                   raw;
        logic [N_EVT_OUT-1:0][EVT_ID_WIDTH-1:0]      sel;
    } udma_ctrl_word_u;

endpackage

`default_nettype wire

//--- compile.f
common/udma_pkg.sv
apb/udma_apb_if.sv
ctrl/udma_event_match.sv
ctrl/udma_ctrl.sv
logic/udma_clock_gate.sv
logic/udma_core.sv
verification/tb_udma_core.sv

//--- ctrl/udma_ctrl.sv
/*
 * uDMA control unit on target index 0.
 * Holds the peripheral clock-enable mask and the event-select bytes,
 * with read-back, and hosts the event matcher.
 */

`timescale 1ns/1ps
`default_nettype none

module udma_ctrl #(
    parameter int N_PERIPHS = 4
) (
    input  logic                                 sys_clk_i,
    input  logic                                 rst_n_i,

    input  logic [udma_pkg::APB_DATA_WIDTH-1:0]  cfg_data_i,
    input  logic [udma_pkg::REG_ADDR_WIDTH-1:0]  cfg_addr_i,
    input  logic                                 cfg_valid_i,
    input  logic                                 cfg_rwn_i,
    output logic [udma_pkg::APB_DATA_WIDTH-1:0]  cfg_data_o,
    output logic                                 cfg_ready_o,

    input  logic                                 event_valid_i,
    input  logic [udma_pkg::EVT_ID_WIDTH-1:0]    event_data_i,
    output logic [udma_pkg::N_EVT_OUT-1:0]       event_o,
    output logic [N_PERIPHS-1:0]                 cg_value_o
);

    import udma_pkg::*;

    udma_ctrl_word_u      wr_word;
    udma_ctrl_word_u      evt_sel_q;
    logic [N_PERIPHS-1:0] cg_q;
    logic                 wr_en;

    assign wr_word.raw = cfg_data_i;

    // Always ready, so every valid write completes on this edge
    assign cfg_ready_o = cfg_valid_i;
    assign wr_en       = cfg_valid_i & ~cfg_rwn_i;

    ////////////////////////////////////////
    // Register write
    ////////////////////////////////////////

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cg_q          <= '0;
            evt_sel_q.raw <= '0;
        end
        else if (wr_en)
        begin
            case (cfg_addr_i)
                CTRL_REG_CG:  cg_q      <= wr_word.raw[N_PERIPHS-1:0];
                CTRL_REG_EVT: evt_sel_q <= wr_word;
                default:      ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read-back
    ////////////////////////////////////////

    always_comb
    begin
        cfg_data_o = '0;
        case (cfg_addr_i)
            CTRL_REG_CG:  cfg_data_o[N_PERIPHS-1:0] = cg_q;
            CTRL_REG_EVT: cfg_data_o = evt_sel_q.raw;
            default:      cfg_data_o = '0;
        endcase
    end

    assign cg_value_o = cg_q;

    udma_event_match u_event_match (
        .sys_clk_i     ( sys_clk_i     ),
        .rst_n_i       ( rst_n_i       ),
        .evt_sel_i     ( evt_sel_q     ),
        .event_valid_i ( event_valid_i ),
        .event_data_i  ( event_data_i  ),
        .event_o       ( event_o       )
    );

endmodule

`default_nettype wire

//--- ctrl/udma_event_match.sv
/*
 * Event matcher.
 * Compares the incoming event id against four select bytes and
 * registers the match vector as one-cycle pulses.
 */

`timescale 1ns/1ps
`default_nettype none

module udma_event_match (
    input  logic                               sys_clk_i,
    input  logic                               rst_n_i,
    input  udma_pkg::udma_ctrl_word_u          evt_sel_i,
    input  logic                               event_valid_i,
    input  logic [udma_pkg::EVT_ID_WIDTH-1:0]  event_data_i,
    output logic [udma_pkg::N_EVT_OUT-1:0]     event_o
);

    import udma_pkg::*;

    logic [N_EVT_OUT-1:0] match;

    // Several selects may hold the same id and then fire together
    always_comb
    begin
        for (int k = 0; k < N_EVT_OUT; k++)
        begin
            match[k] = event_valid_i && (event_data_i == evt_sel_i.sel[k]);
        end
    end

    // No handshake, one event is taken every cycle
    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            event_o <= '0;
        end
        else
        begin
            event_o <= match;
        end
    end

endmodule

`default_nettype wire

//--- logic/udma_clock_gate.sv
/*
 * Latch-based clock gate.
 * Optional enable synchroniser into the gated clock's domain,
 * with a test enable that forces the clock to run.
 */

`timescale 1ns/1ps
`default_nettype none

module udma_clock_gate #(
    parameter int SYNC_STAGES = 0
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    input  logic test_en_i,
    output logic clk_o
);

    logic en_s;
    logic en_latch;

    generate
        if (SYNC_STAGES == 0)
        begin : g_bypass
            assign en_s = en_i;
        end
        else
        begin : g_sync
            logic [SYNC_STAGES-1:0] sync_q;

            always_ff @(posedge clk_i or negedge rst_n_i)
            begin
                if (!rst_n_i)
                begin
                    sync_q <= '0;
                end
                else
                begin
                    sync_q <= (sync_q << 1) | SYNC_STAGES'(en_i);
                end
            end

            assign en_s = sync_q[SYNC_STAGES-1];
        end
    endgenerate

    // Transparent only while the clock is low, so the high phase is never cut
    always_latch
    begin
        if (!clk_i)
        begin
            en_latch = en_s | test_en_i;
        end
    end

    assign clk_o = clk_i & en_latch;

endmodule

`default_nettype wire

//--- logic/udma_core.sv
/*
 * Top level of the uDMA configuration core.
 * Connects the APB slave, the control unit and the per-peripheral
 * system and peripheral clock gates.
 */

`timescale 1ns/1ps
`default_nettype none

module udma_core #(
    parameter int N_PERIPHS = 4
) (
    input  logic                                 sys_clk_i,
    input  logic                                 per_clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 dft_cg_enable_i,

    input  logic [udma_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
    input  logic [udma_pkg::APB_DATA_WIDTH-1:0]  pwdata_i,
    input  logic                                 pwrite_i,
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    output logic [udma_pkg::APB_DATA_WIDTH-1:0]  prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,

    input  logic                                 event_valid_i,
    input  logic [udma_pkg::EVT_ID_WIDTH-1:0]    event_data_i,
    output logic [udma_pkg::N_EVT_OUT-1:0]       event_o,

    output logic [N_PERIPHS-1:0]                 periph_sys_clk_o,
    output logic [N_PERIPHS-1:0]                 periph_per_clk_o,

    output logic [udma_pkg::APB_DATA_WIDTH-1:0]  periph_data_o,
    output logic [udma_pkg::REG_ADDR_WIDTH-1:0]  periph_addr_o,
    output logic                                 periph_rwn_o,
    output logic [N_PERIPHS-1:0]                 periph_valid_o,
    input  logic [N_PERIPHS-1:0][udma_pkg::APB_DATA_WIDTH-1:0] periph_data_i,
    input  logic [N_PERIPHS-1:0]                 periph_ready_i
);

    import udma_pkg::*;

    logic [N_PERIPHS:0][APB_DATA_WIDTH-1:0] s_per_rdata;
    logic [N_PERIPHS:0]                     s_per_ready;
    logic [N_PERIPHS:0]                     s_per_valid;
    logic [N_PERIPHS-1:0]                   s_cg_value;

    // Target 0 is the control unit, the rest go off-chip
    assign periph_valid_o               = s_per_valid[N_PERIPHS:1];
    assign s_per_rdata[N_PERIPHS:1]     = periph_data_i;
    assign s_per_ready[N_PERIPHS:1]     = periph_ready_i;

    udma_apb_if #(
        .N_PERIPHS ( N_PERIPHS )
    ) u_apb_if (
        .paddr_i     ( paddr_i       ),
        .pwdata_i    ( pwdata_i      ),
        .pwrite_i    ( pwrite_i      ),
        .psel_i      ( psel_i        ),
        .penable_i   ( penable_i     ),
        .prdata_o    ( prdata_o      ),
        .pready_o    ( pready_o      ),
        .pslverr_o   ( pslverr_o     ),
        .per_data_o  ( periph_data_o ),
        .per_addr_o  ( periph_addr_o ),
        .per_rwn_o   ( periph_rwn_o  ),
        .per_valid_o ( s_per_valid   ),
        .per_rdata_i ( s_per_rdata   ),
        .per_ready_i ( s_per_ready   )
    );

    udma_ctrl #(
        .N_PERIPHS ( N_PERIPHS )
    ) u_ctrl (
        .sys_clk_i     ( sys_clk_i      ),
        .rst_n_i       ( rst_n_i        ),
        .cfg_data_i    ( periph_data_o  ),
        .cfg_addr_i    ( periph_addr_o  ),
        .cfg_valid_i   ( s_per_valid[0] ),
        .cfg_rwn_i     ( periph_rwn_o   ),
        .cfg_data_o    ( s_per_rdata[0] ),
        .cfg_ready_o   ( s_per_ready[0] ),
        .event_valid_i ( event_valid_i  ),
        .event_data_i  ( event_data_i   ),
        .event_o       ( event_o        ),
        .cg_value_o    ( s_cg_value     )
    );

    ////////////////////////////////////////
    // Per-peripheral clock gates
    ////////////////////////////////////////

    for (genvar i = 0; i < N_PERIPHS; i++)
    begin : g_periph_cg
        udma_clock_gate #(
            .SYNC_STAGES ( 0 )
        ) u_gate_sys (
            .clk_i     ( sys_clk_i           ),
            .rst_n_i   ( rst_n_i             ),
            .en_i      ( s_cg_value[i]       ),
            .test_en_i ( dft_cg_enable_i     ),
            .clk_o     ( periph_sys_clk_o[i] )
        );

        // Mask bit lives in the system domain, so resync it first
        udma_clock_gate #(
            .SYNC_STAGES ( 2 )
        ) u_gate_per (
            .clk_i     ( per_clk_i           ),
            .rst_n_i   ( rst_n_i             ),
            .en_i      ( s_cg_value[i]       ),
            .test_en_i ( dft_cg_enable_i     ),
            .clk_o     ( periph_per_clk_o[i] )
        );
    end

endmodule

`default_nettype wire

//--- verification/tb_udma_core.sv
/*
 * Testbench for the uDMA configuration core.
 * Clocks, APB tasks, a peripheral model, reference functions,
 * reset, register, forwarding, event and clock-gating tests.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_udma_core;

    import udma_pkg::*;

    localparam int N_PERIPHS = 4;
    // The tests need a few hundred cycles, this bound leaves ample slack
    localparam int TIMEOUT_CYCLES = 5000;
    localparam logic [N_PERIPHS-1:0][31:0] PER_KEY = {32'h4000_00d4, 32'h3000_00c3,
                                                      32'h2000_00b2, 32'h1000_00a1};

    logic sys_clk;
    logic per_clk;
    logic rst_n;
    logic dft_cg_enable;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic pwrite;
    logic psel;
    logic penable;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic event_valid;
    logic [7:0] event_data;
    logic [N_EVT_OUT-1:0] event_o;
    logic [N_PERIPHS-1:0] periph_sys_clk;
    logic [N_PERIPHS-1:0] periph_per_clk;
    logic [31:0] periph_wdata;
    logic [4:0] periph_addr;
    logic periph_rwn;
    logic [N_PERIPHS-1:0] periph_valid;
    logic [N_PERIPHS-1:0][31:0] periph_rdata;
    logic [N_PERIPHS-1:0] periph_ready;

    // Values seen at the completing edge of the last APB access
    logic [31:0] cap_rdata;
    logic [31:0] cap_data;
    logic [4:0] cap_addr;
    logic [N_PERIPHS-1:0] cap_valid;
    logic cap_err;
    logic cap_rwn;
    logic cap_done;
    int cap_waits;

    int model_delay;
    int last_delay;
    logic model_busy;
    logic [N_PERIPHS-1:0] model_valid;
    logic [N_EVT_OUT-1:0] evt_exp_d;
    logic [N_EVT_OUT-1:0] evt_exp_q;
    logic evt_chk_d;
    logic evt_chk_q;
    logic counting;
    int sys_cnt [N_PERIPHS];
    int per_cnt [N_PERIPHS];
    int src_sys_cnt;
    int src_per_cnt;
    int checks;
    int errors;
    int err_mark;
    int cycles;

    udma_core #(
        .N_PERIPHS ( N_PERIPHS )
    ) u_udma_core (
        .sys_clk_i        ( sys_clk        ),
        .per_clk_i        ( per_clk        ),
        .rst_n_i          ( rst_n          ),
        .dft_cg_enable_i  ( dft_cg_enable  ),
        .paddr_i          ( paddr          ),
        .pwdata_i         ( pwdata         ),
        .pwrite_i         ( pwrite         ),
        .psel_i           ( psel           ),
        .penable_i        ( penable        ),
        .prdata_o         ( prdata         ),
        .pready_o         ( pready         ),
        .pslverr_o        ( pslverr        ),
        .event_valid_i    ( event_valid    ),
        .event_data_i     ( event_data     ),
        .event_o          ( event_o        ),
        .periph_sys_clk_o ( periph_sys_clk ),
        .periph_per_clk_o ( periph_per_clk ),
        .periph_data_o    ( periph_wdata   ),
        .periph_addr_o    ( periph_addr    ),
        .periph_rwn_o     ( periph_rwn     ),
        .periph_valid_o   ( periph_valid   ),
        .periph_data_i    ( periph_rdata   ),
        .periph_ready_i   ( periph_ready   )
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    initial
    begin
        per_clk = 1'b0;
        forever #70 per_clk = ~per_clk;
    end

    ////////////////////////////////////////
    // Reference functions
    ////////////////////////////////////////

    function automatic logic [31:0] exp_reg_read(input logic [4:0] rg,
                                                 input logic [N_PERIPHS-1:0] cg,
                                                 input logic [31:0] sel);
        case (rg)
            5'd0:    return {{(32-N_PERIPHS){1'b0}}, cg};
            5'd1:    return sel;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [N_EVT_OUT-1:0] exp_events(input logic valid,
                                                        input logic [7:0] id,
                                                        input logic [31:0] sel);
        logic [N_EVT_OUT-1:0] m;
        for (int k = 0; k < N_EVT_OUT; k++)
        begin
            m[k] = valid && (id == sel[8*k +: 8]);
        end
        return m;
    endfunction

    function automatic logic [31:0] exp_periph_read(input int p, input logic [4:0] rg);
        return {27'h0, rg} ^ PER_KEY[p];
    endfunction

    function automatic logic [11:0] make_addr(input logic [4:0] idx, input logic [4:0] rg);
        return {idx, rg, 2'b00};
    endfunction

    ////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %-10s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic apb_transfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata);
        @(negedge sys_clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge sys_clk);
        penable   = 1'b1;
        cap_waits = 0;
        cap_done  = 1'b0;
        while (!cap_done)
        begin
            @(posedge sys_clk);
            cap_waits++;
            if (pready)
            begin
                cap_done  = 1'b1;
                cap_rdata = prdata;
                cap_err   = pslverr;
                cap_valid = periph_valid;
                cap_addr  = periph_addr;
                cap_rwn   = periph_rwn;
                cap_data  = periph_wdata;
            end
        end
        @(negedge sys_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        apb_transfer(addr, 1'b1, wdata);
    endtask

    task automatic apb_read(input logic [11:0] addr);
        apb_transfer(addr, 1'b0, 32'h0);
    endtask

    task automatic measure_clocks(input int n);
        @(negedge sys_clk);
        for (int k = 0; k < N_PERIPHS; k++)
        begin
            sys_cnt[k] = 0;
            per_cnt[k] = 0;
        end
        src_sys_cnt = 0;
        src_per_cnt = 0;
        counting = 1'b1;
        repeat (n) @(negedge sys_clk);
        counting = 1'b0;
    endtask

    task automatic check_clocks(input logic [N_PERIPHS-1:0] en);
        for (int k = 0; k < N_PERIPHS; k++)
        begin
            check($sformatf("periph_sys_clk_o[%0d] edges", k), sys_cnt[k],
                  en[k] ? src_sys_cnt : 0);
            check($sformatf("periph_per_clk_o[%0d] edges", k), per_cnt[k],
                  en[k] ? src_per_cnt : 0);
        end
    endtask

    ////////////////////////////////////////
    // Peripheral model and monitors
    ////////////////////////////////////////

    // The model sees the valid lines as they stood at the last rising edge
    always @(posedge sys_clk)
    begin
        model_valid <= periph_valid;
    end

    // Answers the register address XOR a per-target key after 0 to 3 cycles
    always @(negedge sys_clk)
    begin
        if (|periph_ready)
        begin
            periph_ready = '0;
        end
        else if (|model_valid)
        begin
            for (int k = 0; k < N_PERIPHS; k++)
            begin
                if (model_valid[k])
                begin
                    if (!model_busy)
                    begin
                        model_busy  = 1'b1;
                        model_delay = $urandom % 4;
                        last_delay  = model_delay;
                    end
                    if (model_delay == 0)
                    begin
                        periph_rdata[k] = {27'h0, periph_addr} ^ PER_KEY[k];
                        periph_ready[k] = 1'b1;
                        model_busy      = 1'b0;
                    end
                    else
                    begin
                        model_delay--;
                    end
                end
            end
        end
    end

    always @(posedge sys_clk)
    begin
        evt_exp_q <= evt_exp_d;
        evt_chk_q <= evt_chk_d;
    end

    always @(negedge sys_clk)
    begin
        if (evt_chk_q)
        begin
            check("event_o", event_o, evt_exp_q);
        end
    end

    always @(posedge sys_clk)
    begin
        if (counting)
        begin
            src_sys_cnt++;
        end
    end

    always @(posedge per_clk)
    begin
        if (counting)
        begin
            src_per_cnt++;
        end
    end

    for (genvar k = 0; k < N_PERIPHS; k++)
    begin : g_edge_cnt
        always @(posedge periph_sys_clk[k])
        begin
            if (counting)
            begin
                sys_cnt[k]++;
            end
        end

        always @(posedge periph_per_clk[k])
        begin
            if (counting)
            begin
                per_cnt[k]++;
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        logic [4:0] idx;
        logic [4:0] rg;
        logic [7:0] id;
        logic [31:0] wdata;
        logic [N_PERIPHS-1:0] ref_cg;
        logic [31:0] ref_sel;
        int pick;

        void'($urandom(51));
        rst_n = 1'b0;
        dft_cg_enable = 1'b0;
        paddr = '0;
        pwdata = '0;
        pwrite = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        event_valid = 1'b0;
        event_data = '0;
        periph_rdata = '0;
        periph_ready = '0;
        model_busy = 1'b0;
        model_delay = 0;
        last_delay = 0;
        evt_exp_d = '0;
        evt_chk_d = 1'b0;
        checks = 0;
        errors = 0;
        err_mark = 0;
        src_sys_cnt = 0;
        src_per_cnt = 0;
        counting = 1'b0;
        for (int k = 0; k < N_PERIPHS; k++)
        begin
            sys_cnt[k] = 0;
            per_cnt[k] = 0;
        end
        // Count gated edges from the middle of reset through the cycles after it
        @(negedge sys_clk);
        counting = 1'b1;
        @(negedge sys_clk);
        rst_n = 1'b1;
        repeat (4) @(negedge sys_clk);
        counting = 1'b0;
        check_clocks('0);
        check("event_o", event_o, '0);
        ref_cg = '0;
        ref_sel = '0;
        apb_read(make_addr(0, CTRL_REG_CG));
        check("prdata_o", cap_rdata, exp_reg_read(CTRL_REG_CG, ref_cg, ref_sel));
        apb_read(make_addr(0, CTRL_REG_EVT));
        check("prdata_o", cap_rdata, exp_reg_read(CTRL_REG_EVT, ref_cg, ref_sel));
        report_test("reset");

        for (int i = 0; i < 8; i++)
        begin
            wdata = $urandom;
            apb_write(make_addr(0, CTRL_REG_CG), wdata);
            ref_cg = wdata[N_PERIPHS-1:0];
            wdata = $urandom;
            apb_write(make_addr(0, CTRL_REG_EVT), wdata);
            ref_sel = wdata;
            rg = 2 + $urandom % 30;
            apb_write(make_addr(0, rg), $urandom);
            apb_read(make_addr(0, CTRL_REG_CG));
            check("prdata_o", cap_rdata, exp_reg_read(CTRL_REG_CG, ref_cg, ref_sel));
            apb_read(make_addr(0, CTRL_REG_EVT));
            check("prdata_o", cap_rdata, exp_reg_read(CTRL_REG_EVT, ref_cg, ref_sel));
            apb_read(make_addr(0, rg));
            check("prdata_o", cap_rdata, exp_reg_read(rg, ref_cg, ref_sel));
            check("pslverr_o", cap_err, 1'b0);
        end
        report_test("registers");

        for (int i = 0; i < 40; i++)
        begin
            idx = 1 + $urandom % N_PERIPHS;
            rg = $urandom;
            wdata = $urandom;
            if ($urandom % 2)
            begin
                apb_write(make_addr(idx, rg), wdata);
                check("periph_rwn_o", cap_rwn, 1'b0);
                check("periph_data_o", cap_data, wdata);
            end
            else
            begin
                apb_read(make_addr(idx, rg));
                check("periph_rwn_o", cap_rwn, 1'b1);
                check("prdata_o", cap_rdata, exp_periph_read(idx - 1, rg));
            end
            check("periph_valid_o", cap_valid, 1 << (idx - 1));
            check("periph_addr_o", cap_addr, rg);
            check("pslverr_o", cap_err, 1'b0);
            // One cycle for the model to see valid, its delay, then the completing edge
            check("access cycles", cap_waits, last_delay + 2);
        end
        for (int i = 0; i < 6; i++)
        begin
            idx = 5 + $urandom % 27;
            apb_transfer(make_addr(idx, $urandom), i % 2, $urandom);
            check("pslverr_o", cap_err, 1'b1);
            check("prdata_o", cap_rdata, 32'h0);
            check("periph_valid_o", cap_valid, '0);
            check("access cycles", cap_waits, 1);
        end
        report_test("forwarding");

        wdata = $urandom;
        wdata[23:16] = wdata[7:0];
        apb_write(make_addr(0, CTRL_REG_EVT), wdata);
        ref_sel = wdata;
        for (int i = 0; i < 48; i++)
        begin
            pick = $urandom % 4;
            id = ($urandom % 2) ? ref_sel[8*pick +: 8] : 8'($urandom);
            @(negedge sys_clk);
            event_valid = ($urandom % 8) != 0;
            event_data = id;
            evt_exp_d = exp_events(event_valid, id, ref_sel);
            evt_chk_d = 1'b1;
        end
        @(negedge sys_clk);
        event_valid = 1'b0;
        evt_exp_d = '0;
        @(negedge sys_clk);
        evt_chk_d = 1'b0;
        @(negedge sys_clk);
        report_test("events");

        for (int i = 0; i < 2; i++)
        begin
            wdata = $urandom;
            apb_write(make_addr(0, CTRL_REG_CG), wdata);
            ref_cg = wdata[N_PERIPHS-1:0];
            repeat (4) @(posedge per_clk);
            measure_clocks(20);
            check_clocks(ref_cg);
            @(negedge sys_clk);
            dft_cg_enable = 1'b1;
            repeat (4) @(posedge per_clk);
            measure_clocks(20);
            check_clocks('1);
            @(negedge sys_clk);
            dft_cg_enable = 1'b0;
        end
        report_test("clock gate");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
